// File: hdl/cplx_pkg.sv
package cplx_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int HALF_W    = 16;          // One Q1.15 component
    localparam int WORD_W    = 2 * HALF_W;  // Re in upper half, im in lower half
    localparam int ADDR_W    = 8;
    localparam int INST_W    = 32;
    localparam int CNT_W     = 3;           // In-flight counter, holds up to 4

    // Memory and pipeline depths
    localparam int MEM_DEPTH = 256;
    localparam int RD_LAT    = 2;                   // RAM read, address reg plus output reg
    localparam int ALU_LAT   = 2;                   // Products, then sum and shift
    localparam int WB_DELAY  = RD_LAT + ALU_LAT;    // Destination delay to write-back

    ////////////////////
    // Vector types
    ////////////////////
    typedef logic signed [HALF_W-1:0]   half_t;
    typedef logic        [WORD_W-1:0]   word_t;
    typedef logic        [ADDR_W-1:0]   addr_t;
    typedef logic        [INST_W-1:0]   inst_t;  // {op, src2, src1, dest}
    typedef logic signed [2*HALF_W-1:0] prod_t;  // Full 16x16 product
    typedef logic signed [2*HALF_W:0]   acc_t;   // Sum of two products, one guard bit
    typedef logic        [CNT_W-1:0]    cnt_t;

    // Opcode field, inst[31:24]
    typedef enum logic [7:0] {
        OP_ADD  = 8'h00,
        OP_SUB  = 8'h01,
        OP_MUL  = 8'h02,
        OP_CONJ = 8'h03
    } opcode_e;

    // Host write regions
    typedef enum logic [1:0] {
        REG_LOAD  = 2'd0,
        REG_SHIFT = 2'd1,
        REG_ALPHA = 2'd2
    } region_e;

    ////////////////////
    // Address map
    ////////////////////
    localparam addr_t LOAD_BASE  = 8'h00;  // Load samples
    localparam addr_t SHIFT_BASE = 8'h20;  // Shift samples, 32
    localparam addr_t WB_BASE    = 8'h40;  // Write-back pointer at reset, 64
    localparam addr_t ALPHA_BASE = 8'h80;  // Alpha coefficients, 128

endpackage

// File: hdl/sdp_bram.sv
module sdp_bram (
    input  logic            clk,
    input  logic            rst,
    input  logic            we,
    input  cplx_pkg::addr_t waddr,
    input  cplx_pkg::word_t din,
    input  logic            re,
    input  cplx_pkg::addr_t raddr,
    output cplx_pkg::word_t dout
);

    cplx_pkg::word_t mem [cplx_pkg::MEM_DEPTH];
    cplx_pkg::addr_t raddr_q;   // Read address stage
    logic            re_q;      // Output stage enable

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // First read cycle, capture address
    always_ff @(posedge clk) begin
        if (re) begin
            raddr_q <= raddr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            re_q <= 1'b0;
        end else begin
            re_q <= re;
        end
    end

    // Second read cycle, output register holds until next read
    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
        end else if (re_q) begin
            dout <= mem[raddr_q];  // Old data on same-edge write
        end
    end

endmodule

// File: hdl/data_mem.sv
module data_mem (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,      // Host write, already registered by ctrl
    input  cplx_pkg::region_e wr_region,
    input  cplx_pkg::word_t   wr_data,
    input  logic              wb_v,       // ALU result write-back
    input  cplx_pkg::word_t   wb_data,
    input  logic              rd_en,
    input  logic              inst_v,
    input  cplx_pkg::addr_t   src1,
    input  cplx_pkg::addr_t   src2,
    input  cplx_pkg::addr_t   dest,
    output cplx_pkg::word_t   douta,      // Source 1
    output cplx_pkg::word_t   doutb       // Source 2
);

    cplx_pkg::addr_t ptr_load;
    cplx_pkg::addr_t ptr_shift;
    cplx_pkg::addr_t ptr_alpha;
    cplx_pkg::addr_t host_addr;
    cplx_pkg::addr_t dest_d [cplx_pkg::WB_DELAY];  // Last stage is write-back pointer
    cplx_pkg::addr_t waddr;
    cplx_pkg::word_t din;
    logic            we;

    ////////////////////
    // Region pointers
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_load  <= cplx_pkg::LOAD_BASE;
            ptr_shift <= cplx_pkg::SHIFT_BASE;
            ptr_alpha <= cplx_pkg::ALPHA_BASE;
        end else if (wr_en) begin
            case (wr_region)  // Post-increment, 8-bit wrap
                cplx_pkg::REG_LOAD:  ptr_load  <= ptr_load + 1'b1;
                cplx_pkg::REG_SHIFT: ptr_shift <= ptr_shift + 1'b1;
                cplx_pkg::REG_ALPHA: ptr_alpha <= ptr_alpha + 1'b1;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (wr_region)
            cplx_pkg::REG_SHIFT: host_addr = ptr_shift;
            cplx_pkg::REG_ALPHA: host_addr = ptr_alpha;
            default:             host_addr = ptr_load;
        endcase
    end

    ////////////////////
    // Destination delay
    ////////////////////
    // Capture dest with the instruction, walk it down alongside
    // the RAM read and the ALU
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cplx_pkg::WB_DELAY; i++) begin
                dest_d[i] <= cplx_pkg::WB_BASE;
            end
        end else begin
            if (inst_v) begin
                dest_d[0] <= dest;
            end
            for (int i = 1; i < cplx_pkg::WB_DELAY; i++) begin
                dest_d[i] <= dest_d[i-1];
            end
        end
    end

    // Write select, host first
    assign we    = wr_en | wb_v;
    assign waddr = wr_en ? host_addr : dest_d[cplx_pkg::WB_DELAY-1];
    assign din   = wr_en ? wr_data : wb_data;

    ////////////////////
    // Banks
    ////////////////////
    // Same word into both, each bank serves one source
    sdp_bram bank_a (
        .clk   (clk),
        .rst   (rst),
        .we    (we),
        .waddr (waddr),
        .din   (din),
        .re    (rd_en),
        .raddr (src1),
        .dout  (douta)
    );

    sdp_bram bank_b (
        .clk   (clk),
        .rst   (rst),
        .we    (we),
        .waddr (waddr),
        .din   (din),
        .re    (rd_en),
        .raddr (src2),
        .dout  (doutb)
    );

    // Back-pressure in ctrl must keep these apart
    a_no_wr_collision : assert property (
        @(posedge clk) disable iff (rst) !(wr_en && wb_v)
    );

    a_region_valid : assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (wr_region inside {cplx_pkg::REG_LOAD, cplx_pkg::REG_SHIFT,
                                     cplx_pkg::REG_ALPHA})
    );

endmodule

// File: hdl/cplx_alu.sv
module cplx_alu (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_v,
    input  cplx_pkg::opcode_e op,
    input  cplx_pkg::word_t   a,
    input  cplx_pkg::word_t   b,
    output logic              res_v,
    output cplx_pkg::word_t   res
);

    cplx_pkg::half_t   a_re;
    cplx_pkg::half_t   a_im;
    cplx_pkg::half_t   b_re;
    cplx_pkg::half_t   b_im;

    // Stage 1 registers
    logic              v1;
    cplx_pkg::opcode_e op1;
    cplx_pkg::prod_t   p_rr;
    cplx_pkg::prod_t   p_ii;
    cplx_pkg::prod_t   p_ri;
    cplx_pkg::prod_t   p_ir;
    cplx_pkg::half_t   s_re;   // ADD, SUB, CONJ result halves
    cplx_pkg::half_t   s_im;

    // Stage 2 combinational
    cplx_pkg::acc_t    acc_re;
    cplx_pkg::acc_t    acc_im;
    cplx_pkg::word_t   res_n;

    assign a_re = a[31:16];
    assign a_im = a[15:0];
    assign b_re = b[31:16];
    assign b_im = b[15:0];

    ////////////////////
    // Stage 1
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
        end else begin
            v1 <= in_v;
        end
    end

    always_ff @(posedge clk) begin
        op1  <= op;
        p_rr <= a_re * b_re;  // Cross products, signed
        p_ii <= a_im * b_im;
        p_ri <= a_re * b_im;
        p_ir <= a_im * b_re;
        case (op)
            cplx_pkg::OP_SUB: begin
                s_re <= a_re - b_re;
                s_im <= a_im - b_im;
            end
            cplx_pkg::OP_CONJ: begin
                s_re <= a_re;
                s_im <= -a_im;   // -(-1) wraps to -1
            end
            default: begin      // ADD, unused for MUL
                s_re <= a_re + b_re;
                s_im <= a_im + b_im;
            end
        endcase
    end

    ////////////////////
    // Stage 2
    ////////////////////
    assign acc_re = p_rr - p_ii;
    assign acc_im = p_ri + p_ir;

    always_comb begin
        if (op1 == cplx_pkg::OP_MUL) begin
            res_n = {acc_re[30:15], acc_im[30:15]};  // >>> 15, keep low 16
        end else begin
            res_n = {s_re, s_im};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_v <= 1'b0;
        end else begin
            res_v <= v1;
        end
    end

    always_ff @(posedge clk) begin
        res <= res_n;
    end

    a_alu_latency : assert property (
        @(posedge clk) disable iff (rst) res_v == $past(in_v, cplx_pkg::ALU_LAT)
    );

endmodule

// File: hdl/core_ctrl.sv
module core_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_v,
    input  cplx_pkg::region_e wr_region,
    input  cplx_pkg::word_t   wr_data,
    input  logic              inst_v,
    input  cplx_pkg::inst_t   inst,
    input  logic              alu_res_v,
    output logic              wr_ready,
    output logic              mem_wr_en,
    output cplx_pkg::region_e mem_wr_region,
    output cplx_pkg::word_t   mem_wr_data,
    output logic              mem_inst_v,
    output cplx_pkg::addr_t   src1,
    output cplx_pkg::addr_t   src2,
    output cplx_pkg::addr_t   dest,
    output logic              rd_en,
    output logic              alu_v,
    output cplx_pkg::opcode_e alu_op,
    output logic              wb_v,
    output logic              busy
);

    logic [cplx_pkg::RD_LAT-1:0] v_pipe;                 // Valid across RAM read
    cplx_pkg::opcode_e           op_pipe [cplx_pkg::RD_LAT];
    cplx_pkg::cnt_t              inflight;

    ////////////////////
    // Host writes
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr_en <= 1'b0;
        end else begin
            mem_wr_en <= wr_v & wr_ready;  // Stored one edge after accept
        end
    end

    always_ff @(posedge clk) begin
        mem_wr_region <= wr_region;
        mem_wr_data   <= wr_data;
    end

    ////////////////////
    // Issue
    ////////////////////
    assign mem_inst_v = inst_v;
    assign rd_en      = inst_v;
    assign src2       = inst[23:16];
    assign src1       = inst[15:8];
    assign dest       = inst[7:0];

    // Opcode rides along with the read
    always_ff @(posedge clk) begin
        if (rst) begin
            v_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[cplx_pkg::RD_LAT-2:0], inst_v};
        end
    end

    always_ff @(posedge clk) begin
        op_pipe[0] <= cplx_pkg::opcode_e'(inst[31:24]);
        for (int i = 1; i < cplx_pkg::RD_LAT; i++) begin
            op_pipe[i] <= op_pipe[i-1];
        end
    end

    assign alu_v  = v_pipe[cplx_pkg::RD_LAT-1];
    assign alu_op = op_pipe[cplx_pkg::RD_LAT-1];
    assign wb_v   = alu_res_v;  // Write-back on each result

    // In-flight count, issue to result
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= '0;
        end else begin
            case ({inst_v, alu_res_v})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

    assign busy     = (inflight != '0);
    assign wr_ready = ~busy;

    // Accepted write means the whole read and ALU pipe is empty
    a_no_wr_while_busy : assert property (
        @(posedge clk) disable iff (rst)
        (wr_v && wr_ready) |-> (v_pipe == '0 && !alu_res_v)
    );

endmodule

// File: hdl/cplx_core.sv
module cplx_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_v,
    input  cplx_pkg::region_e wr_region,
    input  cplx_pkg::word_t   wr_data,
    input  logic              inst_v,
    input  cplx_pkg::inst_t   inst,
    output logic              wr_ready,
    output logic              res_v,
    output cplx_pkg::word_t   res,
    output logic              busy
);

    // Ctrl to memory
    logic              mem_wr_en;
    cplx_pkg::region_e mem_wr_region;
    cplx_pkg::word_t   mem_wr_data;
    logic              mem_inst_v;
    cplx_pkg::addr_t   src1;
    cplx_pkg::addr_t   src2;
    cplx_pkg::addr_t   dest;
    logic              rd_en;
    logic              wb_v;

    // Memory and ctrl to ALU
    cplx_pkg::word_t   douta;
    cplx_pkg::word_t   doutb;
    logic              alu_v;
    cplx_pkg::opcode_e alu_op;

    core_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .wr_v          (wr_v),
        .wr_region     (wr_region),
        .wr_data       (wr_data),
        .inst_v        (inst_v),
        .inst          (inst),
        .alu_res_v     (res_v),
        .wr_ready      (wr_ready),
        .mem_wr_en     (mem_wr_en),
        .mem_wr_region (mem_wr_region),
        .mem_wr_data   (mem_wr_data),
        .mem_inst_v    (mem_inst_v),
        .src1          (src1),
        .src2          (src2),
        .dest          (dest),
        .rd_en         (rd_en),
        .alu_v         (alu_v),
        .alu_op        (alu_op),
        .wb_v          (wb_v),
        .busy          (busy)
    );

    data_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (mem_wr_en),
        .wr_region (mem_wr_region),
        .wr_data   (mem_wr_data),
        .wb_v      (wb_v),
        .wb_data   (res),      // Result goes back to memory
        .rd_en     (rd_en),
        .inst_v    (mem_inst_v),
        .src1      (src1),
        .src2      (src2),
        .dest      (dest),
        .douta     (douta),
        .doutb     (doutb)
    );

    cplx_alu u_alu (
        .clk   (clk),
        .rst   (rst),
        .in_v  (alu_v),
        .op    (alu_op),
        .a     (douta),
        .b     (doutb),
        .res_v (res_v),
        .res   (res)
    );

endmodule

// File: bench/cplx_core_tb.sv
module cplx_core_tb;

    localparam int N_LOAD  = 36;    // 16 load, 16 shift, 4 alpha words
    localparam int N_EXTRA = 2;     // Busy write sequence
    localparam int N_STEPS = 20;
    localparam int TIMEOUT = (N_STEPS + N_EXTRA) * 8 + N_LOAD + 50;

    typedef struct packed {
        logic [7:0] op;
        logic [7:0] src1;
        logic [7:0] src2;
        logic [7:0] dest;
        logic       b2b;    // Next entry issues on the very next cycle
    } step_t;

    ////////////////////
    // Instruction table
    ////////////////////
    localparam step_t STEPS [N_STEPS] = '{
        '{cplx_pkg::OP_CONJ, 8'd0,   8'd0,   8'd64, 1'b0},  // One per region
        '{cplx_pkg::OP_CONJ, 8'd32,  8'd0,   8'd65, 1'b0},
        '{cplx_pkg::OP_CONJ, 8'd128, 8'd0,   8'd66, 1'b0},
        '{cplx_pkg::OP_ADD,  8'd1,   8'd33,  8'd67, 1'b0},
        '{cplx_pkg::OP_SUB,  8'd2,   8'd34,  8'd68, 1'b0},
        '{cplx_pkg::OP_ADD,  8'd3,   8'd35,  8'd69, 1'b0},
        '{cplx_pkg::OP_SUB,  8'd4,   8'd36,  8'd70, 1'b0},
        '{cplx_pkg::OP_MUL,  8'd5,   8'd37,  8'd71, 1'b0},
        '{cplx_pkg::OP_MUL,  8'd14,  8'd46,  8'd72, 1'b0},  // -1 times -1
        '{cplx_pkg::OP_MUL,  8'd15,  8'd47,  8'd73, 1'b0},  // (-1-j) squared
        '{cplx_pkg::OP_MUL,  8'd6,   8'd129, 8'd74, 1'b0},  // Alpha operand
        '{cplx_pkg::OP_MUL,  8'd14,  8'd38,  8'd75, 1'b0},  // -1 times random
        '{cplx_pkg::OP_ADD,  8'd7,   8'd39,  8'd76, 1'b1},  // Four back to back
        '{cplx_pkg::OP_SUB,  8'd8,   8'd40,  8'd77, 1'b1},
        '{cplx_pkg::OP_MUL,  8'd9,   8'd41,  8'd78, 1'b1},
        '{cplx_pkg::OP_CONJ, 8'd10,  8'd42,  8'd79, 1'b0},
        '{cplx_pkg::OP_ADD,  8'd11,  8'd43,  8'd90, 1'b0},  // Write-back chain
        '{cplx_pkg::OP_CONJ, 8'd90,  8'd0,   8'd91, 1'b0},
        '{cplx_pkg::OP_MUL,  8'd90,  8'd90,  8'd92, 1'b0},
        '{cplx_pkg::OP_CONJ, 8'd92,  8'd0,   8'd93, 1'b0}
    };

    logic              clk;
    logic              rst;
    logic              wr_v;
    cplx_pkg::region_e wr_region;
    cplx_pkg::word_t   wr_data;
    logic              inst_v;
    cplx_pkg::inst_t   inst;
    logic              wr_ready;
    logic              res_v;
    cplx_pkg::word_t   res;
    logic              busy;

    logic [31:0] model_mem [256];   // Expected memory contents
    logic [7:0]  model_ptr [3];     // Expected region pointers
    logic [31:0] exp_q [$];         // Results still due, in issue order
    int          errors = 0;
    int          cycles = 0;
    int          batch;

    cplx_core uut (
        .clk       (clk),
        .rst       (rst),
        .wr_v      (wr_v),
        .wr_region (wr_region),
        .wr_data   (wr_data),
        .inst_v    (inst_v),
        .inst      (inst),
        .wr_ready  (wr_ready),
        .res_v     (res_v),
        .res       (res),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Timeout, no completion within %0d cycles", TIMEOUT);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Q1.15 complex ops, each half wraps at 16 bits
    function automatic logic [31:0] model_result(input logic [7:0] op,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b);
        longint ar;
        longint ai;
        longint br;
        longint bi;
        longint re;
        longint im;
        ar = $signed(a[31:16]);
        ai = $signed(a[15:0]);
        br = $signed(b[31:16]);
        bi = $signed(b[15:0]);
        case (op)
            cplx_pkg::OP_ADD: begin
                re = ar + br;
                im = ai + bi;
            end
            cplx_pkg::OP_SUB: begin
                re = ar - br;
                im = ai - bi;
            end
            cplx_pkg::OP_MUL: begin
                re = (ar * br - ai * bi) >>> 15;  // Truncate toward minus infinity
                im = (ar * bi + ai * br) >>> 15;
            end
            default: begin     // CONJ of source 1
                re = ar;
                im = -ai;
            end
        endcase
        return {re[15:0], im[15:0]};
    endfunction

    ////////////////////
    // Driver tasks
    ////////////////////
    task automatic write_word(input cplx_pkg::region_e region, input logic [31:0] data);
        @(negedge clk);
        wr_v      = 1'b1;
        wr_region = region;
        wr_data   = data;
        check("wr_ready", wr_ready, 1);
        model_mem[model_ptr[int'(region)]] = data;
        model_ptr[int'(region)] = model_ptr[int'(region)] + 8'd1;
    endtask

    task automatic end_writes();
        @(negedge clk);
        wr_v = 1'b0;
    endtask

    task automatic issue(input logic [7:0] op, input logic [7:0] s1,
                         input logic [7:0] s2, input logic [7:0] d);
        logic [31:0] exp;
        @(negedge clk);
        inst_v = 1'b1;
        inst   = {op, s2, s1, d};
        exp    = model_result(op, model_mem[s1], model_mem[s2]);
        exp_q.push_back(exp);
        model_mem[d] = exp;     // Readers come 6+ cycles later
    endtask

    // Busy until the last pulse of the batch has gone
    task automatic wait_batch(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            inst_v = 1'b0;
            if (res_v) begin
                seen++;
            end
            check("busy", busy, 1);
            check("wr_ready", wr_ready, 0);
        end
        @(negedge clk);
        check("busy", busy, 0);
        check("wr_ready", wr_ready, 1);
        check("res_v", res_v, 0);
    endtask

    // Result monitor
    always @(negedge clk) begin
        if (!rst && res_v) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result pulse seen with no instruction pending");
            end else begin
                check("res", res, exp_q.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(32'hfbc9a158));
        rst       = 1'b1;
        wr_v      = 1'b0;
        wr_region = cplx_pkg::REG_LOAD;
        wr_data   = '0;
        inst_v    = 1'b0;
        inst      = '0;
        model_ptr[0] = cplx_pkg::LOAD_BASE;
        model_ptr[1] = cplx_pkg::SHIFT_BASE;
        model_ptr[2] = cplx_pkg::ALPHA_BASE;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check("wr_ready", wr_ready, 1);
        check("busy", busy, 0);
        check("res_v", res_v, 0);

        // Region fill, last two words of load and shift hold -1 cases
        for (int i = 0; i < 14; i++) begin
            write_word(cplx_pkg::REG_LOAD, $urandom());
        end
        write_word(cplx_pkg::REG_LOAD, 32'h8000_0000);
        write_word(cplx_pkg::REG_LOAD, 32'h8000_8000);
        for (int i = 0; i < 14; i++) begin
            write_word(cplx_pkg::REG_SHIFT, $urandom());
        end
        write_word(cplx_pkg::REG_SHIFT, 32'h8000_0000);
        write_word(cplx_pkg::REG_SHIFT, 32'h8000_8000);
        for (int i = 0; i < 4; i++) begin
            write_word(cplx_pkg::REG_ALPHA, $urandom());
        end
        end_writes();

        batch = 0;
        for (int i = 0; i < N_STEPS; i++) begin
            issue(STEPS[i].op, STEPS[i].src1, STEPS[i].src2, STEPS[i].dest);
            batch++;
            if (!STEPS[i].b2b) begin
                wait_batch(batch);
                batch = 0;
            end
        end

        // Host write during flight must be dropped
        issue(cplx_pkg::OP_ADD, 8'd12, 8'd44, 8'd94);
        @(negedge clk);
        inst_v    = 1'b0;
        wr_v      = 1'b1;
        wr_region = cplx_pkg::REG_SHIFT;
        wr_data   = 32'hdead_beef;
        check("wr_ready", wr_ready, 0);
        @(negedge clk);
        wr_v = 1'b0;
        wait_batch(1);
        write_word(cplx_pkg::REG_SHIFT, 32'h1234_8000);  // Lands at 48 if pointer held
        end_writes();
        issue(cplx_pkg::OP_CONJ, 8'd48, 8'd0, 8'd95);
        wait_batch(1);

        @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d results never arrived", exp_q.size());
        end
        $display("Run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: cplx_core.f
hdl/cplx_pkg.sv
hdl/sdp_bram.sv
hdl/data_mem.sv
hdl/cplx_alu.sv
hdl/core_ctrl.sv
hdl/cplx_core.sv
bench/cplx_core_tb.sv

// File: Makefile
TB = cplx_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv -f cplx_core.f --top-module $(TB) -Mdir obj_dir

run: build
	./obj_dir/V$(TB) > sim.log 2>&1; cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

lint:
	verilator --lint-only --timing -sv -f cplx_core.f --top-module cplx_core

clean:
	rm -rf obj_dir sim.log
